// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP       := tb_frame_capture
RTL_TOP   := frame_capture_top
FILELIST  := verilog.f
OBJDIR    := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== hdl/capture_consts.svh ====
`ifndef CAPTURE_CONSTS_SVH
`define CAPTURE_CONSTS_SVH

// Frame buffer geometry, in 32-bit words
`define FB_DEPTH        256
`define REGION_A_BASE   0
`define REGION_B_BASE   256
`define MEM_WORDS       512

// Luma weights, the weighted sum is taken >> 8
`define LUMA_R          77
`define LUMA_G          150
`define LUMA_B          29

`endif

// ==== hdl/capture_pkg.sv ====
package capture_pkg;

    // Red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] pixel_t;

    // Top byte always zero
    typedef logic [31:0] mem_word_t;

    typedef logic [8:0]  mem_addr_t;

    // 0 to 256 pixels per frame
    typedef logic [8:0]  pixel_count_t;

    typedef struct packed {
        logic   de;
        logic   hsync;
        logic   vsync;
        pixel_t pixel;
    } video_bus_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
        mem_word_t data;
    } mem_wr_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ARMED,
        WR_CAPTURE,
        WR_COPY_WAIT
    } writer_state_t;

    typedef enum logic [1:0] {
        CP_IDLE,
        CP_RUN,
        CP_DRAIN
    } copy_state_t;

endpackage

// ==== hdl/frame_capture_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_capture_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  capture_pkg::video_bus_t   video_i,
    input  logic                      capture_i,
    output logic                      busy_o,
    output logic                      done_o,
    input  logic                      kick_i,
    input  capture_pkg::mem_addr_t    read_addr_i,
    input  capture_pkg::pixel_count_t read_num_i,
    output logic                      rd_busy_o,
    output logic                      rd_valid_o,
    output capture_pkg::mem_word_t    rd_data_o
);
    import capture_pkg::*;

    mem_wr_t      wr_cap;
    mem_wr_t      wr_gray;
    mem_wr_t      wr_ram;
    logic         copy_start;
    logic         copy_done;
    pixel_count_t pixel_count;
    mem_addr_t    gray_rd_addr;
    mem_word_t    gray_rd_data;
    mem_addr_t    host_rd_addr;
    mem_word_t    host_rd_data;

    // Capture and copy never write in the same cycle
    assign wr_ram = wr_cap.en ? wr_cap : wr_gray;

    frame_writer u_frame_writer (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .video_i       (video_i),
        .capture_i     (capture_i),
        .copy_done_i   (copy_done),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .wr_o          (wr_cap),
        .copy_start_o  (copy_start),
        .pixel_count_o (pixel_count)
    );

    gray_copy u_gray_copy (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .start_i       (copy_start),
        .pixel_count_i (pixel_count),
        .rd_addr_o     (gray_rd_addr),
        .rd_data_i     (gray_rd_data),
        .wr_o          (wr_gray),
        .done_o        (copy_done)
    );

    frame_ram u_frame_ram (
        .clk_i      (clk_i),
        .wr_i       (wr_ram),
        .rd0_addr_i (gray_rd_addr),
        .rd0_data_o (gray_rd_data),
        .rd1_addr_i (host_rd_addr),
        .rd1_data_o (host_rd_data)
    );

    host_reader u_host_reader (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .kick_i      (kick_i),
        .read_addr_i (read_addr_i),
        .read_num_i  (read_num_i),
        .busy_o      (rd_busy_o),
        .rd_addr_o   (host_rd_addr),
        .rd_data_i   (host_rd_data),
        .rd_valid_o  (rd_valid_o),
        .rd_data_o   (rd_data_o)
    );

endmodule

`default_nettype wire

// ==== hdl/frame_ram.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "capture_consts.svh"

module frame_ram (
    input  logic                   clk_i,
    input  capture_pkg::mem_wr_t   wr_i,
    input  capture_pkg::mem_addr_t rd0_addr_i,
    output capture_pkg::mem_word_t rd0_data_o,
    input  capture_pkg::mem_addr_t rd1_addr_i,
    output capture_pkg::mem_word_t rd1_data_o
);
    import capture_pkg::*;

    // Regions A and B side by side
    mem_word_t mem [`MEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // Read before write on an address clash
    always_ff @(posedge clk_i) begin
        rd0_data_o <= mem[rd0_addr_i];
        rd1_data_o <= mem[rd1_addr_i];
    end

endmodule

`default_nettype wire

// ==== hdl/frame_writer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "capture_consts.svh"

module frame_writer (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  capture_pkg::video_bus_t   video_i,
    input  logic                      capture_i,
    input  logic                      copy_done_i,
    output logic                      busy_o,
    output logic                      done_o,
    output capture_pkg::mem_wr_t      wr_o,
    output logic                      copy_start_o,
    output capture_pkg::pixel_count_t pixel_count_o
);
    import capture_pkg::*;

    writer_state_t state;
    logic          vsync_q;
    logic          vs_edge;
    pixel_count_t  count;
    logic          store;

    assign vs_edge = video_i.vsync & ~vsync_q;

    // Pixels past the region depth are dropped
    assign store = (state == WR_CAPTURE) && video_i.de &&
                   (count < pixel_count_t'(`FB_DEPTH));

    assign wr_o.en   = store;
    assign wr_o.addr = mem_addr_t'(`REGION_A_BASE) + mem_addr_t'(count);
    assign wr_o.data = {8'h00, video_i.pixel};

    assign pixel_count_o = count;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state        <= WR_IDLE;
            vsync_q      <= 1'b0;
            count        <= '0;
            busy_o       <= 1'b0;
            done_o       <= 1'b0;
            copy_start_o <= 1'b0;
        end else begin
            vsync_q      <= video_i.vsync;
            done_o       <= 1'b0;
            copy_start_o <= 1'b0;

            if (store) begin
                count <= count + 1'b1;
            end

            case (state)
                WR_IDLE: begin
                    if (capture_i) begin
                        state  <= WR_ARMED;
                        busy_o <= 1'b1;
                    end
                end
                WR_ARMED: begin
                    // Frame starts at the next vsync
                    if (vs_edge) begin
                        state <= WR_CAPTURE;
                        count <= '0;
                    end
                end
                WR_CAPTURE: begin
                    if (vs_edge) begin
                        state        <= WR_COPY_WAIT;
                        copy_start_o <= 1'b1;
                    end
                end
                WR_COPY_WAIT: begin
                    if (copy_done_i) begin
                        state  <= WR_IDLE;
                        busy_o <= 1'b0;
                        done_o <= 1'b1;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        count <= pixel_count_t'(`FB_DEPTH));

endmodule

`default_nettype wire

// ==== hdl/gray_copy.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "capture_consts.svh"

module gray_copy (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      start_i,
    input  capture_pkg::pixel_count_t pixel_count_i,
    output capture_pkg::mem_addr_t    rd_addr_o,
    input  capture_pkg::mem_word_t    rd_data_i,
    output capture_pkg::mem_wr_t      wr_o,
    output logic                      done_o
);
    import capture_pkg::*;

    copy_state_t  state;
    pixel_count_t rd_idx;
    pixel_count_t count_q;
    logic         wr_pend;
    mem_addr_t    wr_addr;
    pixel_t       pix;
    logic [15:0]  luma_sum;
    logic [7:0]   luma;

    assign rd_addr_o = mem_addr_t'(`REGION_A_BASE) + mem_addr_t'(rd_idx);

    // RAM data arrives one cycle after the address
    assign pix      = rd_data_i[23:0];
    assign luma_sum = 16'(`LUMA_R * pix[23:16] + `LUMA_G * pix[15:8] + `LUMA_B * pix[7:0]);
    assign luma     = luma_sum[15:8];

    assign wr_o.en   = wr_pend;
    assign wr_o.addr = wr_addr;
    assign wr_o.data = {8'h00, luma, luma, luma};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= CP_IDLE;
            rd_idx  <= '0;
            count_q <= '0;
            wr_pend <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            done_o  <= 1'b0;
            wr_pend <= 1'b0;
            case (state)
                CP_IDLE: begin
                    if (start_i) begin
                        rd_idx  <= '0;
                        count_q <= pixel_count_i;
                        if (pixel_count_i == '0) begin
                            done_o <= 1'b1;
                        end else begin
                            state <= CP_RUN;
                        end
                    end
                end
                CP_RUN: begin
                    wr_pend <= 1'b1;
                    rd_idx  <= rd_idx + 1'b1;
                    if (rd_idx == count_q - 1'b1) begin
                        state <= CP_DRAIN;
                    end
                end
                CP_DRAIN: begin
                    // Last write is on the port this cycle
                    done_o <= 1'b1;
                    state  <= CP_IDLE;
                end
                default: begin
                    state <= CP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == CP_RUN) begin
            wr_addr <= mem_addr_t'(`REGION_B_BASE) + mem_addr_t'(rd_idx);
        end
    end

    a_start_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i |-> (state == CP_IDLE));

endmodule

`default_nettype wire

// ==== hdl/host_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

module host_reader (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      kick_i,
    input  capture_pkg::mem_addr_t    read_addr_i,
    input  capture_pkg::pixel_count_t read_num_i,
    output logic                      busy_o,
    output capture_pkg::mem_addr_t    rd_addr_o,
    input  capture_pkg::mem_word_t    rd_data_i,
    output logic                      rd_valid_o,
    output capture_pkg::mem_word_t    rd_data_o
);
    import capture_pkg::*;

    mem_addr_t    addr_q;
    pixel_count_t remain;
    logic         issue;
    logic         accept;

    assign accept    = kick_i & ~busy_o;
    assign rd_addr_o = addr_q;
    assign rd_data_o = rd_data_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_o     <= 1'b0;
            issue      <= 1'b0;
            remain     <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            // Valid lines up with the RAM read latency
            rd_valid_o <= issue;
            if (accept) begin
                busy_o <= 1'b1;
                issue  <= 1'b1;
                remain <= read_num_i;
            end else if (issue) begin
                remain <= remain - 1'b1;
                if (remain == pixel_count_t'(1)) begin
                    issue <= 1'b0;
                end
            end
            if (rd_valid_o && !issue) begin
                busy_o <= 1'b0;
            end
        end
    end

    // Address wraps at the top of the buffer
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= read_addr_i;
        end else if (issue) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    a_valid_in_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        rd_valid_o |-> busy_o);

endmodule

`default_nettype wire

// ==== tb/tb_frame_capture.sv ====
`timescale 1ns/1ns
`include "capture_consts.svh"

module tb_frame_capture;
    import capture_pkg::*;

    logic         clk_i;
    logic         rst_i;
    video_bus_t   video;
    logic         capture_i;
    logic         busy_o;
    logic         done_o;
    logic         kick_i;
    mem_addr_t    read_addr_i;
    pixel_count_t read_num_i;
    logic         rd_busy_o;
    logic         rd_valid_o;
    mem_word_t    rd_data_o;

    int        seed;
    int        captures;
    int        done_seen;
    int        last_count;
    mem_word_t model_mem [`MEM_WORDS];
    bit        model_ok [`MEM_WORDS];

    frame_capture_top i_dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .video_i     (video),
        .capture_i   (capture_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .kick_i      (kick_i),
        .read_addr_i (read_addr_i),
        .read_num_i  (read_num_i),
        .rd_busy_o   (rd_busy_o),
        .rd_valid_o  (rd_valid_o),
        .rd_data_o   (rd_data_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s (got %h, expected %h)", $time, msg, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at time %0t: %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    // Gray word from the luma weights
    // Sum shifted right by 8 lands in all three bytes
    function automatic mem_word_t luma_word(input mem_word_t w);
        int         sum;
        logic [7:0] y;
        sum = `LUMA_R * int'(w[23:16]) + `LUMA_G * int'(w[15:8]) + `LUMA_B * int'(w[7:0]);
        y = 8'(sum >> 8);
        return {8'h00, y, y, y};
    endfunction

    // One clock step
    // Outputs sampled before new inputs are driven
    task automatic tick();
        @(posedge clk_i);
        #2;
        if (done_o) begin
            done_seen++;
            check(32'(busy_o), 32'd0, "busy_o in the done_o cycle");
        end
    endtask

    task automatic video_idle();
        video = '0;
    endtask

    task automatic random_pixel();
        int r;
        r = $random(seed);
        video       = '0;
        video.de    = 1'b1;
        video.pixel = r[23:0];
    endtask

    task automatic vsync_pulse();
        video_idle();
        video.vsync = 1'b1;
        repeat (3) tick();
        video.vsync = 1'b0;
    endtask

    // Opening vsync then lines with hsync and blanking
    task automatic send_frame(input int lines, input int len, output int stored);
        int l;
        int p;
        stored = 0;
        vsync_pulse();
        repeat (4) tick();
        for (l = 0; l < lines; l++) begin
            video_idle();
            video.hsync = 1'b1;
            repeat (2) tick();
            video.hsync = 1'b0;
            repeat (3) tick();
            for (p = 0; p < len; p++) begin
                random_pixel();
                if (stored < `FB_DEPTH) begin
                    model_mem[mem_addr_t'(`REGION_A_BASE + stored)] = {8'h00, video.pixel};
                    model_ok[mem_addr_t'(`REGION_A_BASE + stored)]  = 1'b1;
                    stored++;
                end
                tick();
            end
        end
        video_idle();
    endtask

    task automatic run_capture(input int lines, input int len);
        int i;
        int waited;
        int stored;
        capture_i = 1'b1;
        tick();
        capture_i = 1'b0;
        captures++;
        check(32'(busy_o), 32'd1, "busy_o after capture_i");
        // Pixels ahead of the first vsync edge must be dropped
        for (i = 0; i < 5 + rand_below(20); i++) begin
            random_pixel();
            capture_i = (i == 2);
            tick();
        end
        capture_i = 1'b0;
        send_frame(lines, len, stored);
        vsync_pulse();
        // Request during the copy pass is ignored
        capture_i = 1'b1;
        tick();
        capture_i = 1'b0;
        waited = 0;
        while (done_seen < captures) begin
            tick();
            waited++;
            if (waited > 4 * `FB_DEPTH) begin
                report_timeout("done_o never followed the capture");
            end
        end
        for (i = 0; i < stored; i++) begin
            model_mem[mem_addr_t'(`REGION_B_BASE + i)] =
                luma_word(model_mem[mem_addr_t'(`REGION_A_BASE + i)]);
            model_ok[mem_addr_t'(`REGION_B_BASE + i)]  = 1'b1;
        end
        last_count = stored;
        repeat (10) tick();
        check(32'(done_seen), 32'(captures), "done_o pulses per accepted capture");
        check(32'(busy_o), 32'd0, "busy_o after done_o");
    endtask

    task automatic host_read(input int addr, input int num);
        int        idx;
        int        waited;
        mem_addr_t a;
        kick_i      = 1'b1;
        read_addr_i = mem_addr_t'(addr);
        read_num_i  = pixel_count_t'(num);
        tick();
        kick_i = 1'b0;
        check(32'(rd_busy_o), 32'd1, "rd_busy_o the cycle after kick_i");
        check(32'(rd_valid_o), 32'd0, "rd_valid_o the cycle after kick_i");
        for (idx = 0; idx < num; idx++) begin
            tick();
            a = mem_addr_t'((addr + idx) % `MEM_WORDS);
            check(32'(rd_valid_o), 32'd1, $sformatf("rd_valid_o for word %0d of run", idx));
            check(32'(rd_busy_o), 32'd1, $sformatf("rd_busy_o for word %0d of run", idx));
            if (model_ok[a]) begin
                check(rd_data_o, model_mem[a], $sformatf("rd_data_o at address %0d", a));
            end
        end
        tick();
        check(32'(rd_valid_o), 32'd0, "rd_valid_o after the run");
        waited = 0;
        while (rd_busy_o) begin
            tick();
            waited++;
            if (waited > 10) begin
                report_timeout("rd_busy_o stayed high after the read run");
            end
        end
    endtask

    initial begin
        int f;
        seed        = 32'h22bd8044;
        captures    = 0;
        done_seen   = 0;
        last_count  = 0;
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        video       = '0;
        capture_i   = 1'b0;
        kick_i      = 1'b0;
        read_addr_i = '0;
        read_num_i  = '0;

        repeat (4) @(posedge clk_i);
        #2;
        check(32'(busy_o), 32'd0, "busy_o in reset");
        check(32'(done_o), 32'd0, "done_o in reset");
        check(32'(rd_busy_o), 32'd0, "rd_busy_o in reset");
        check(32'(rd_valid_o), 32'd0, "rd_valid_o in reset");
        rst_i = 1'b0;
        repeat (3) tick();

        // First frame overflows region A
        run_capture(6, 60);
        host_read(`REGION_A_BASE, `FB_DEPTH);
        host_read(`REGION_B_BASE, `FB_DEPTH);

        for (f = 0; f < 5; f++) begin
            run_capture(2 + rand_below(6), 8 + rand_below(64));
            host_read(`REGION_A_BASE, last_count);
            host_read(last_count, 1 + rand_below(16));
            host_read(`REGION_B_BASE, last_count);
            host_read(rand_below(`MEM_WORDS), 1 + rand_below(64));
        end

        // Run across the top of the buffer
        host_read(`MEM_WORDS - 12, 30);
        check(32'(done_seen), 32'(captures), "done_o pulses over the whole run");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/capture_pkg.sv
hdl/frame_ram.sv
hdl/frame_writer.sv
hdl/gray_copy.sv
hdl/host_reader.sv
hdl/frame_capture_top.sv
tb/tb_frame_capture.sv
